// File: sim.f
+incdir+bench
source/demosaicPkg.sv
source/thresholdPkg.sv
source/pipeDelay.sv
source/bayerWindow.sv
source/frameControl.sv
source/greenInterpolator.sv
source/edgeThreshold.sv
source/demosaicAcpiGreen.sv
bench/demosaicTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= demosaicTb
FILELIST ?= sim.f
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/demosaicModel.svh
`ifndef DEMOSAIC_MODEL_SVH
`define DEMOSAIC_MODEL_SVH

// Sample at (x, y) of the current frame image or zero outside it
function automatic int samplePixel(input int x, input int y);
	int value;
	value = 0;
	if (x >= 0 && y >= 0 && x < frameWidth && y < frameHeight) begin
		value = int'(frameImage[y * frameWidth + x]);
	end
	return value;
endfunction

function automatic int magnitude(input int a);
	return (a < 0) ? -a : a;
endfunction

// Green wherever row and column parity agree
function automatic bit isGreenSite(input int x, input int y);
	return (x % 2) == (y % 2);
endfunction

function automatic int modelGradSum(input int x, input int y);
	return magnitude(samplePixel(x - 1, y) - samplePixel(x + 1, y))
		+ magnitude(samplePixel(x, y - 1) - samplePixel(x, y + 1));
endfunction

function automatic rgb_t modelRgb(input int x, input int y);
	int hGrad;
	int vGrad;
	int hEst;
	int vEst;
	int green;
	rgb_t result;
	hGrad = magnitude(samplePixel(x - 1, y) - samplePixel(x + 1, y));
	vGrad = magnitude(samplePixel(x, y - 1) - samplePixel(x, y + 1));
	if (x == 0) begin
		hEst = samplePixel(x + 1, y);
	end else if (x == frameWidth - 1) begin
		hEst = samplePixel(x - 1, y);
	end else begin
		hEst = (samplePixel(x - 1, y) + samplePixel(x + 1, y)) / 2;
	end
	if (y == 0) begin
		vEst = samplePixel(x, y + 1);
	end else if (y == frameHeight - 1) begin
		vEst = samplePixel(x, y - 1);
	end else begin
		vEst = (samplePixel(x, y - 1) + samplePixel(x, y + 1)) / 2;
	end
	// Follow the direction with the smaller gradient
	if (hGrad > vGrad) begin
		green = vEst;
	end else if (hGrad < vGrad) begin
		green = hEst;
	end else begin
		green = (hEst + vEst) / 2;
	end
	if (isGreenSite(x, y)) begin
		result = '{r: 8'd0, g: 8'(samplePixel(x, y)), b: 8'd0};
	end else if (x % 2 == 1) begin
		result = '{r: 8'd0, g: 8'(green), b: 8'(samplePixel(x, y))};
	end else begin
		result = '{r: 8'(samplePixel(x, y)), g: 8'(green), b: 8'd0};
	end
	return result;
endfunction

// Frame statistic over the red and blue sites only
function automatic int modelFrameStat();
	int total;
	total = 0;
	for (int y = 0; y < frameHeight; y++) begin
		for (int x = 0; x < frameWidth; x++) begin
			if (!isGreenSite(x, y)) begin
				total += modelGradSum(x, y);
			end
		end
	end
	return total;
endfunction

function automatic threshold_t modelThreshold(input int total);
	threshold_t level;
	if (total < int'(testBounds.bound0)) begin
		level = 8'd50;
	end else if (total < int'(testBounds.bound1)) begin
		level = 8'd40;
	end else if (total < int'(testBounds.bound2)) begin
		level = 8'd20;
	end else if (total < int'(testBounds.bound3)) begin
		level = 8'd15;
	end else begin
		level = 8'd8;
	end
	return level;
endfunction

`endif

// File: bench/demosaicTb.sv
`timescale 1ns/1ps
`default_nettype none

module demosaicTb import demosaicPkg::*, thresholdPkg::*; ();

	localparam int frameWidth = 8;
	localparam int frameHeight = 6;
	localparam int framePixels = frameWidth * frameHeight;
	localparam int streamDepth = 512;
	localparam int waitLimit = 2000;
	localparam thresholdBounds_t testBounds = '{
		bound0: 32'd200,
		bound1: 32'd400,
		bound2: 32'd800,
		bound3: 32'd1600
	};
	// Flat levels whose edge gradients land f in each band
	localparam pixel_t bandLevels [5] = '{8'd10, 8'd20, 8'd40, 8'd80, 8'd150};

	logic clk;
	logic reset;
	pixel_t pixelIn;
	logic pixelValid;
	rgb_t rgbOut;
	logic rgbValid;
	logic frameDone;
	threshold_t edgeThresh;

	pixel_t frameImage [framePixels];
	rgb_t expectedStream [streamDepth];
	logic expectedLast [streamDepth];
	int queuedCount = 0;
	int framesSent = 0;
	int outIndex = 0;
	int doneCount = 0;
	int errorCount = 0;
	int passCount = 0;
	int failCount = 0;
	int testErrorBase = 0;
	string currentTest = "startup";
	rgb_t expectedRgb;
	logic expectedDone;

	`include "demosaicModel.svh"

	demosaicAcpiGreen #(
		.imageWidth(frameWidth),
		.imageHeight(frameHeight),
		.bounds(testBounds)
	) dut0 (
		.clk(clk),
		.reset(reset),
		.pixelIn(pixelIn),
		.pixelValid(pixelValid),
		.rgbOut(rgbOut),
		.rgbValid(rgbValid),
		.frameDone(frameDone),
		.edgeThresh(edgeThresh)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic reportValue(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("ERROR %s: %s expected 0x%0h, actual 0x%0h",
			currentTest, what, expected, actual);
		errorCount++;
	endtask

	task automatic reportFailure(input string text);
		$display("%s: %s", currentTest, text);
		errorCount++;
	endtask

	// Output scoreboard position, one entry per valid output
	assign expectedRgb = expectedStream[outIndex];
	assign expectedDone = expectedLast[outIndex];

	always @(posedge clk) begin
		if (reset) begin
			outIndex <= 0;
			doneCount <= 0;
		end else begin
			if (rgbValid) begin
				outIndex <= outIndex + 1;
			end
			if (frameDone) begin
				doneCount <= doneCount + 1;
			end
		end
	end

	rgbMatches: assert property (@(posedge clk) disable iff (reset)
		rgbValid |-> rgbOut == expectedRgb)
		else reportValue("rgbOut", 32'($sampled(expectedRgb)), 32'($sampled(rgbOut)));

	doneOnLast: assert property (@(posedge clk) disable iff (reset)
		rgbValid |-> frameDone == expectedDone)
		else reportValue("frameDone", 32'($sampled(expectedDone)), 32'($sampled(frameDone)));

	doneWithOutput: assert property (@(posedge clk) disable iff (reset)
		frameDone |-> rgbValid)
		else reportFailure("frameDone was high without a valid output");

	task automatic beginTest(input string name);
		currentTest = name;
		testErrorBase = errorCount;
	endtask

	task automatic endTest();
		if (errorCount == testErrorBase) begin
			$display("PASS %s", currentTest);
			passCount++;
		end else begin
			$display("FAIL %s with %0d errors", currentTest, errorCount - testErrorBase);
			failCount++;
		end
	endtask

	task automatic fillFlat(input pixel_t value);
		for (int k = 0; k < framePixels; k++) begin
			frameImage[k] = value;
		end
	endtask

	task automatic fillRandom();
		for (int k = 0; k < framePixels; k++) begin
			frameImage[k] = 8'($urandom);
		end
	endtask

	// Idle cycles before the beat only when gaps are requested
	task automatic driveBeat(input pixel_t value, input bit withGaps);
		int idle;
		idle = 0;
		if (withGaps && ($urandom % 4 == 0)) begin
			idle = int'(1 + $urandom % 3);
		end
		repeat (idle) begin
			@(posedge clk);
			pixelValid <= 1'b0;
			pixelIn <= 8'($urandom);
		end
		@(posedge clk);
		pixelValid <= 1'b1;
		pixelIn <= value;
	endtask

	// Queue the model's outputs, then send the frame and its flush beats
	task automatic playFrame(input bit withGaps);
		for (int k = 0; k < framePixels; k++) begin
			expectedStream[queuedCount + k] = modelRgb(k % frameWidth, k / frameWidth);
			expectedLast[queuedCount + k] = (k == framePixels - 1);
		end
		queuedCount += framePixels;
		framesSent++;
		for (int k = 0; k < framePixels; k++) begin
			driveBeat(frameImage[k], withGaps);
		end
		for (int k = 0; k < frameWidth + 4; k++) begin
			driveBeat(8'($urandom), withGaps);
		end
	endtask

	task automatic settle();
		int waited;
		waited = 0;
		@(posedge clk);
		pixelValid <= 1'b0;
		while (doneCount < framesSent && waited < waitLimit) begin
			@(posedge clk);
			waited++;
		end
		if (doneCount < framesSent) begin
			reportFailure("timed out waiting for the frame to finish");
		end
		assert (outIndex == queuedCount)
			else reportValue("output count", 32'(queuedCount), 32'(outIndex));
	endtask

	task automatic checkThreshold(input threshold_t expected);
		assert (edgeThresh == expected)
			else reportValue("edgeThresh", 32'(expected), 32'(edgeThresh));
	endtask

	initial begin
		threshold_t expectedT;
		void'($urandom(32'h22cd793b));
		reset <= 1'b1;
		pixelValid <= 1'b0;
		pixelIn <= '0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);

		beginTest("reset state");
		assert (rgbValid == 1'b0) else reportValue("rgbValid", 32'd0, 32'(rgbValid));
		assert (frameDone == 1'b0) else reportValue("frameDone", 32'd0, 32'(frameDone));
		checkThreshold(8'd8);
		endTest();

		beginTest("flat frame");
		fillFlat(8'd100);
		playFrame(1'b0);
		settle();
		endTest();

		beginTest("random frame with gaps");
		fillRandom();
		playFrame(1'b1);
		settle();
		endTest();

		for (int band = 0; band < 5; band++) begin
			beginTest($sformatf("threshold band %0d", band));
			fillFlat(bandLevels[band]);
			expectedT = modelThreshold(modelFrameStat());
			playFrame(1'b0);
			settle();
			checkThreshold(expectedT);
			endTest();
		end

		// A busy frame goes first so that a stale f would push T down
		beginTest("back-to-back frames");
		fillRandom();
		playFrame(1'b0);
		fillFlat(8'd10);
		expectedT = modelThreshold(modelFrameStat());
		playFrame(1'b0);
		settle();
		checkThreshold(expectedT);
		endTest();

		$display("Tests: %0d passed, %0d failed, %0d errors", passCount, failCount, errorCount);
		if (errorCount == 0 && failCount == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: source/demosaicAcpiGreen.sv
`timescale 1ns/1ps
`default_nettype none

module demosaicAcpiGreen import demosaicPkg::*, thresholdPkg::*; #(
	parameter int imageWidth = 1920,
	parameter int imageHeight = 1080,
	parameter thresholdBounds_t bounds = defaultBounds
) (
	input wire clk,
	input wire reset,
	input wire pixel_t pixelIn,
	input wire pixelValid,
	output rgb_t rgbOut,
	output logic rgbValid,
	output logic frameDone,
	output threshold_t edgeThresh
);

	crossWindow_t window;
	pixelTag_t tag;
	frameStat_t stat;

	bayerWindow #(.imageWidth(imageWidth)) bayerWindow0 (
		.clk(clk),
		.reset(reset),
		.pixelIn(pixelIn),
		.pixelValid(pixelValid),
		.window(window)
	);

	frameControl #(.imageWidth(imageWidth), .imageHeight(imageHeight)) frameControl0 (
		.clk(clk),
		.reset(reset),
		.pixelValid(pixelValid),
		.tag(tag)
	);

	greenInterpolator #(
		.imageWidth(imageWidth),
		.imageHeight(imageHeight)
	) greenInterpolator0 (
		.clk(clk),
		.reset(reset),
		.pixelValid(pixelValid),
		.window(window),
		.tag(tag),
		.rgbOut(rgbOut),
		.rgbValid(rgbValid),
		.frameDone(frameDone),
		.stat(stat)
	);

	edgeThreshold #(.bounds(bounds)) edgeThreshold0 (
		.clk(clk),
		.reset(reset),
		.stat(stat),
		.edgeThresh(edgeThresh)
	);

endmodule

`default_nettype wire

// File: source/edgeThreshold.sv
`timescale 1ns/1ps
`default_nettype none

module edgeThreshold import thresholdPkg::*; #(
	parameter thresholdBounds_t bounds = defaultBounds
) (
	input wire clk,
	input wire reset,
	input wire frameStat_t stat,
	output threshold_t edgeThresh
);

	statSum_t frameSum;
	statSum_t frameTotal;

	// Includes the sample arriving with frame end
	assign frameTotal = stat.accumulate ? frameSum + statSum_t'(stat.gradSum) : frameSum;

	always_ff @(posedge clk) begin
		if (reset) begin
			frameSum <= '0;
			edgeThresh <= threshReset;
		end else if (stat.frameEnd) begin
			frameSum <= '0;
			if (frameTotal < bounds.bound0) begin
				edgeThresh <= threshLevel0;
			end else if (frameTotal < bounds.bound1) begin
				edgeThresh <= threshLevel1;
			end else if (frameTotal < bounds.bound2) begin
				edgeThresh <= threshLevel2;
			end else if (frameTotal < bounds.bound3) begin
				edgeThresh <= threshLevel3;
			end else begin
				edgeThresh <= threshLevel4;
			end
		end else begin
			frameSum <= frameTotal;
		end
	end

endmodule

`default_nettype wire

// File: source/greenInterpolator.sv
`timescale 1ns/1ps
`default_nettype none

module greenInterpolator import demosaicPkg::*, thresholdPkg::*; #(
	parameter int imageWidth = 1920,
	parameter int imageHeight = 1080
) (
	input wire clk,
	input wire reset,
	input wire pixelValid,
	input wire crossWindow_t window,
	input wire pixelTag_t tag,
	output rgb_t rgbOut,
	output logic rgbValid,
	output logic frameDone,
	output frameStat_t stat
);

	localparam int latency = 3;

	typedef struct packed {
		pixel_t hGrad;
		pixel_t vGrad;
		pixel_t hEst;
		pixel_t vEst;
	} gradStage_t;

	typedef struct packed {
		pixel_t hEst;
		pixel_t vEst;
		pixel_t avgEst;
		logic hGreater;
		logic hLess;
		gradSum_t gradSum;
	} choiceStage_t;

	logic firstCol;
	logic lastCol;
	logic firstRow;
	logic lastRow;
	pixel_t aboveMasked;
	pixel_t belowMasked;
	pixel_t leftMasked;
	pixel_t rightMasked;
	logic [8:0] hPairSum;
	logic [8:0] vPairSum;
	logic [8:0] estSum;
	gradStage_t stage1;
	choiceStage_t stage2;
	pixel_t greenOut;
	gradSum_t gradOut;
	pixelTag_t tagDelayed;
	pixel_t centerDelayed;
	bayerSite_e site;

	function automatic pixel_t absDiff(input pixel_t a, input pixel_t b);
		return (a > b) ? a - b : b - a;
	endfunction

	assign firstCol = tag.pos.x == '0;
	assign lastCol = tag.pos.x == coordWidth'(imageWidth - 1);
	assign firstRow = tag.pos.y == '0;
	assign lastRow = tag.pos.y == coordWidth'(imageHeight - 1);

	// Neighbors outside the frame read as zero
	assign aboveMasked = firstRow ? '0 : window.above;
	assign belowMasked = lastRow ? '0 : window.below;
	assign leftMasked = firstCol ? '0 : window.left;
	assign rightMasked = lastCol ? '0 : window.right;

	assign hPairSum = {1'b0, window.left} + {1'b0, window.right};
	assign vPairSum = {1'b0, window.above} + {1'b0, window.below};
	assign estSum = {1'b0, stage1.hEst} + {1'b0, stage1.vEst};

	always_ff @(posedge clk) begin
		if (pixelValid) begin
			// Beat 1
			stage1.hGrad <= absDiff(leftMasked, rightMasked);
			stage1.vGrad <= absDiff(aboveMasked, belowMasked);
			if (firstCol) begin
				stage1.hEst <= window.right;
			end else if (lastCol) begin
				stage1.hEst <= window.left;
			end else begin
				stage1.hEst <= hPairSum[8:1];
			end
			if (firstRow) begin
				stage1.vEst <= window.below;
			end else if (lastRow) begin
				stage1.vEst <= window.above;
			end else begin
				stage1.vEst <= vPairSum[8:1];
			end

			// Beat 2
			stage2.hEst <= stage1.hEst;
			stage2.vEst <= stage1.vEst;
			stage2.avgEst <= estSum[8:1];
			stage2.hGreater <= stage1.hGrad > stage1.vGrad;
			stage2.hLess <= stage1.hGrad < stage1.vGrad;
			stage2.gradSum <= gradSum_t'(stage1.hGrad) + gradSum_t'(stage1.vGrad);

			// Beat 3 interpolates along the smoother direction
			if (stage2.hGreater) begin
				greenOut <= stage2.vEst;
			end else if (stage2.hLess) begin
				greenOut <= stage2.hEst;
			end else begin
				greenOut <= stage2.avgEst;
			end
			gradOut <= stage2.gradSum;
		end
	end

	pipeDelay #(.depth(latency), .payload_t(pixelTag_t)) tagDelay (
		.clk(clk),
		.reset(reset),
		.enable(pixelValid),
		.din(tag),
		.dout(tagDelayed)
	);

	pipeDelay #(.depth(latency), .payload_t(pixel_t)) centerDelay (
		.clk(clk),
		.reset(reset),
		.enable(pixelValid),
		.din(window.center),
		.dout(centerDelayed)
	);

	assign site = bayerSite(tagDelayed.pos.y[0], tagDelayed.pos.x[0]);

	always_comb begin
		case (site)
			siteRed: rgbOut = '{r: centerDelayed, g: greenOut, b: '0};
			siteBlue: rgbOut = '{r: '0, g: greenOut, b: centerDelayed};
			default: rgbOut = '{r: '0, g: centerDelayed, b: '0};
		endcase
	end

	assign rgbValid = tagDelayed.valid & pixelValid;
	assign frameDone = tagDelayed.last & pixelValid;

	// Only interpolated sites feed the frame statistic
	assign stat = '{
		gradSum: gradOut,
		accumulate: rgbValid && (site != siteGreen),
		frameEnd: frameDone
	};

endmodule

`default_nettype wire

// File: source/frameControl.sv
`timescale 1ns/1ps
`default_nettype none

module frameControl import demosaicPkg::*; #(
	parameter int imageWidth = 1920,
	parameter int imageHeight = 1080
) (
	input wire clk,
	input wire reset,
	input wire pixelValid,
	output pixelTag_t tag
);

	localparam int framePixels = imageWidth * imageHeight;
	// Real pixels plus the flush that drains buffers and pipeline
	localparam int frameBeats = framePixels + imageWidth + 4;
	// Beats until the first pixel reaches the window center
	localparam int fillBeats = imageWidth + 1;
	localparam int beatWidth = $clog2(frameBeats);

	logic [beatWidth-1:0] beatCount;
	logic [coordWidth-1:0] xPos;
	logic [coordWidth-1:0] yPos;
	logic centerValid;
	logic lastCenter;

	assign centerValid = (beatCount >= beatWidth'(fillBeats))
		&& (beatCount < beatWidth'(fillBeats + framePixels));
	assign lastCenter = beatCount == beatWidth'(fillBeats + framePixels - 1);

	always_ff @(posedge clk) begin
		if (reset) begin
			beatCount <= '0;
			xPos <= '0;
			yPos <= '0;
		end else if (pixelValid) begin
			if (beatCount == beatWidth'(frameBeats - 1)) begin
				beatCount <= '0;
			end else begin
				beatCount <= beatCount + 1'b1;
			end

			// Raster step once per real center
			if (centerValid) begin
				if (xPos == coordWidth'(imageWidth - 1)) begin
					xPos <= '0;
					if (yPos == coordWidth'(imageHeight - 1)) begin
						yPos <= '0;
					end else begin
						yPos <= yPos + 1'b1;
					end
				end else begin
					xPos <= xPos + 1'b1;
				end
			end
		end
	end

	assign tag = '{
		pos: '{x: xPos, y: yPos},
		valid: centerValid,
		last: lastCenter
	};

endmodule

`default_nettype wire

// File: source/bayerWindow.sv
`timescale 1ns/1ps
`default_nettype none

module bayerWindow import demosaicPkg::*; #(
	parameter int imageWidth = 1920
) (
	input wire clk,
	input wire reset,
	input wire pixel_t pixelIn,
	input wire pixelValid,
	output crossWindow_t window
);

	localparam int ptrWidth = (imageWidth > 1) ? $clog2(imageWidth) : 1;

	// Circular line buffers, one row each
	pixel_t lineMid [imageWidth];
	pixel_t lineTop [imageWidth];
	logic [ptrWidth-1:0] linePtr;

	// Tap 0 of each row is the buffer output itself
	pixel_t midRowIn;
	pixel_t topRowIn;

	// Tap 1 of each row, plus tap 2 of the middle row
	pixel_t belowTap;
	pixel_t centerTap;
	pixel_t leftTap;
	pixel_t aboveTap;

	assign midRowIn = lineMid[linePtr];
	assign topRowIn = lineTop[linePtr];

	always_ff @(posedge clk) begin
		if (pixelValid) begin
			lineMid[linePtr] <= pixelIn;
			lineTop[linePtr] <= midRowIn;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			linePtr <= '0;
			belowTap <= '0;
			centerTap <= '0;
			leftTap <= '0;
			aboveTap <= '0;
		end else if (pixelValid) begin
			if (linePtr == ptrWidth'(imageWidth - 1)) begin
				linePtr <= '0;
			end else begin
				linePtr <= linePtr + 1'b1;
			end
			belowTap <= pixelIn;
			centerTap <= midRowIn;
			leftTap <= centerTap;
			aboveTap <= topRowIn;
		end
	end

	// Right neighbor is the newest sample of the middle row
	assign window = '{
		center: centerTap,
		above: aboveTap,
		below: belowTap,
		left: leftTap,
		right: midRowIn
	};

endmodule

`default_nettype wire

// File: source/pipeDelay.sv
`timescale 1ns/1ps
`default_nettype none

module pipeDelay #(
	parameter int depth = 1,
	parameter type payload_t = logic
) (
	input wire clk,
	input wire reset,
	input wire enable,
	input wire payload_t din,
	output payload_t dout
);

	payload_t stages [depth];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < depth; i++) begin
				stages[i] <= '0;
			end
		end else if (enable) begin
			stages[0] <= din;
			for (int i = 1; i < depth; i++) begin
				stages[i] <= stages[i-1];
			end
		end
	end

	assign dout = stages[depth-1];

endmodule

`default_nettype wire

// File: source/thresholdPkg.sv
`default_nettype none

package thresholdPkg;

	typedef logic [31:0] statSum_t;
	typedef logic [8:0] gradSum_t;
	typedef logic [7:0] threshold_t;

	// Band edges of the frame statistic, lowest first
	typedef struct packed {
		statSum_t bound0;
		statSum_t bound1;
		statSum_t bound2;
		statSum_t bound3;
	} thresholdBounds_t;

	typedef struct packed {
		gradSum_t gradSum;
		logic accumulate;
		logic frameEnd;
	} frameStat_t;

	// Tuned for 1080p frames
	localparam thresholdBounds_t defaultBounds = '{
		bound0: 32'd73242,
		bound1: 32'd102539,
		bound2: 32'd146484,
		bound3: 32'd292965
	};

	// Flat frames get a high edge threshold, busy frames a low one
	localparam threshold_t threshLevel0 = 8'd50;
	localparam threshold_t threshLevel1 = 8'd40;
	localparam threshold_t threshLevel2 = 8'd20;
	localparam threshold_t threshLevel3 = 8'd15;
	localparam threshold_t threshLevel4 = 8'd8;
	localparam threshold_t threshReset = threshLevel4;

endpackage

`default_nettype wire

// File: source/demosaicPkg.sv
`default_nettype none

package demosaicPkg;

	localparam int coordWidth = 16;

	typedef logic [7:0] pixel_t;

	typedef struct packed {
		logic [coordWidth-1:0] x;
		logic [coordWidth-1:0] y;
	} pixelPos_t;

	// Cross-shaped neighborhood of one Bayer sample
	typedef struct packed {
		pixel_t center;
		pixel_t above;
		pixel_t below;
		pixel_t left;
		pixel_t right;
	} crossWindow_t;

	typedef struct packed {
		pixel_t r;
		pixel_t g;
		pixel_t b;
	} rgb_t;

	typedef struct packed {
		pixelPos_t pos;
		logic valid;
		logic last;
	} pixelTag_t;

	typedef enum logic [1:0] {
		siteGreen,
		siteRed,
		siteBlue
	} bayerSite_e;

	// Green where parities match and blue on even rows
	function automatic bayerSite_e bayerSite(input logic yOdd, input logic xOdd);
		bayerSite_e site;
		if (yOdd == xOdd) begin
			site = siteGreen;
		end else if (xOdd) begin
			site = siteBlue;
		end else begin
			site = siteRed;
		end
		return site;
	endfunction

endpackage

`default_nettype wire
